//--- common/monitor_settings.svh
`ifndef MONITOR_SETTINGS_SVH
`define MONITOR_SETTINGS_SVH

// Vector sizes
`define MON_WIDTH       32  // Inputs and outputs per tick
`define MON_ADDR_BITS   5   // Selects one bit of a vector

// Program storage
`define MON_MEM_LEN     32  // Program bytes in the scan chain
`define MON_PC_BITS     8   // PC and program length

// Tick framing
`define MON_TICK_BITS   16  // Cycles per tick

// Evaluation resources
`define MON_TIMER_BITS  12  // Saturating tick counters
`define MON_TIMERS      4
`define MON_STACK_LEN   6   // Bit stack depth

`endif

//--- common/monitor_pkg.sv
`include "monitor_settings.svh"

package monitor_pkg;

    // Opcode in bits 7:6 of each program byte
    typedef enum logic [1:0] {
        OP_PUSH  = 2'd0,    // Push snapshot bit
        OP_LOGIC = 2'd1,    // Two pops, LUT result pushed
        OP_EDIT  = 2'd2,    // Conditional output bit write
        OP_TIMER = 2'd3     // Compare (two bytes) or reset
    } op_t;

    // One program byte
    typedef struct packed {
        op_t        op;     // Bits 7:6
        logic       flag;   // Edit value or timer reset select in bit 5
        logic [4:0] arg;    // Bit address, LUT or timer fields
    } insn_t;

    // Tick counter value
    typedef logic [`MON_TIMER_BITS-1:0] timer_t;

    // Input or output vector
    typedef logic [`MON_WIDTH-1:0] vec_t;

    // Program counter and program length
    typedef logic [`MON_PC_BITS-1:0] pc_t;

endpackage

//--- hw/scan_config.sv
`include "monitor_settings.svh"

module scan_config #(
    parameter int mem_len = `MON_MEM_LEN  // Program bytes
) (
    input  logic                      clk,
    input  logic                      scan_reset,      // Clears whole chain
    input  logic                      scan_en,         // Shift one bit per clock
    input  logic                      scan_in,
    input  monitor_pkg::pc_t          pc,
    output logic                      scan_out,
    output monitor_pkg::pc_t          cfg_prog_len,
    output logic [`MON_TICK_BITS-1:0] cfg_tick_len,
    output monitor_pkg::vec_t         cfg_check_mask,  // Bits that raise violation
    output monitor_pkg::insn_t        insn,            // Byte at pc
    output logic [7:0]                imm              // Byte at pc+1
);
    import monitor_pkg::*;

    // Field offsets, counted from the input end of the chain
    localparam int tick_lsb  = `MON_PC_BITS;
    localparam int mask_lsb  = tick_lsb + `MON_TICK_BITS;
    localparam int mem_lsb   = mask_lsb + `MON_WIDTH;
    localparam int chain_len = mem_lsb + 8 * mem_len;

    // Bit 0 takes scan_in, top bit drives scan_out
    // Layout {mem[mem_len-1] .. mem[0], check_mask, tick_len, prog_len}
    logic [chain_len-1:0]     chain;
    logic [`MON_PC_BITS:0]    addr_insn;  // One extra bit so pc+1 never wraps
    logic [`MON_PC_BITS:0]    addr_imm;

    // Program byte lookup, zero past the end of memory
    function automatic logic [7:0] read_byte(input logic [`MON_PC_BITS:0] addr);
        logic [7:0] data;
        data = 8'h00;
        if (addr < mem_len) begin
            data = chain[mem_lsb + 8 * addr +: 8];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (scan_reset) begin
            chain <= '0;
        end else if (scan_en) begin
            chain <= {chain[chain_len-2:0], scan_in};  // Fields arrive MSB first
        end
    end

    assign scan_out       = chain[chain_len-1];
    assign cfg_prog_len   = chain[tick_lsb-1:0];
    assign cfg_tick_len   = chain[mask_lsb-1:tick_lsb];
    assign cfg_check_mask = chain[mem_lsb-1:mask_lsb];

    assign addr_insn = {1'b0, pc};
    assign addr_imm  = {1'b0, pc} + 1'b1;

    always_comb begin
        insn = insn_t'(read_byte(addr_insn));  // Current instruction
        imm  = read_byte(addr_imm);            // Only meaningful for timer compare
    end

endmodule

//--- hw/tick_sequencer.sv
`include "monitor_settings.svh"

module tick_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      scan_en,         // Holds sequencer idle
    input  monitor_pkg::pc_t          cfg_prog_len,
    input  logic [`MON_TICK_BITS-1:0] cfg_tick_len,
    input  monitor_pkg::insn_t        insn,
    output monitor_pkg::pc_t          pc,
    output logic                      event_setup,     // Cycle 0 of each tick
    output logic                      event_flush,     // Last cycle of each tick
    output logic                      push_en,
    output logic                      logic_en,
    output logic                      edit_en,
    output logic                      timer_cmp_en,
    output logic                      timer_reset_en,
    output logic                      pop_en
);
    import monitor_pkg::*;

    logic                      running;      // Ticks in progress
    logic [`MON_TICK_BITS-1:0] tick_cnt;     // Cycle within tick
    logic                      tick_last;
    logic                      prog_active;  // Instruction executes this cycle
    logic                      two_byte;     // Timer compare carries an immediate
    pc_t                       pc_step;

    assign tick_last   = tick_cnt == cfg_tick_len - 1'b1;
    assign event_setup = running && tick_cnt == '0;
    assign event_flush = running && tick_last;

    // Program runs from cycle 1 until pc reaches prog_len
    assign prog_active = running && tick_cnt != '0 && pc < cfg_prog_len;

    assign two_byte = insn.op == OP_TIMER && !insn.flag;
    assign pc_step  = two_byte ? pc_t'(2) : pc_t'(1);

    always_ff @(posedge clk) begin
        if (reset || scan_en) begin
            running  <= 1'b0;
            tick_cnt <= '0;
            pc       <= '0;
        end else begin
            running <= 1'b1;  // First setup in the next cycle
            if (running) begin
                tick_cnt <= tick_last ? '0 : tick_cnt + 1'b1;
            end
            if (event_setup) begin
                pc <= '0;
            end else if (prog_active) begin
                pc <= pc + pc_step;
            end
        end
    end

    // Strobes decoded only while the program runs
    always_comb begin
        push_en        = 1'b0;
        logic_en       = 1'b0;
        edit_en        = 1'b0;
        timer_cmp_en   = 1'b0;
        timer_reset_en = 1'b0;
        pop_en         = 1'b0;
        if (prog_active) begin
            case (insn.op)
                OP_PUSH:  push_en  = 1'b1;
                OP_LOGIC: logic_en = 1'b1;
                OP_EDIT:  edit_en  = 1'b1;  // Stack left as is
                OP_TIMER: begin
                    if (insn.flag) begin
                        timer_reset_en = 1'b1;  // Conditional on stack top
                        pop_en         = 1'b1;
                    end else begin
                        timer_cmp_en = 1'b1;
                        push_en      = 1'b1;  // Compare result goes on stack
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hw/timer_bank.sv
`include "monitor_settings.svh"

module timer_bank (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,        // Once per tick, at flush
    input  logic       cmp_en,
    input  logic [4:0] insn_arg,    // [2] eq/lt, [1:0] select, [3:0] reset mask
    input  logic [7:0] imm,
    input  logic       reset_en,
    input  logic       stack_top,   // Condition for timer reset
    output logic       cmp_result
);
    import monitor_pkg::*;

    timer_t timers [`MON_TIMERS];  // Ticks since last reset
    timer_t sel_timer;
    timer_t limit;
    logic   cmp_eq;
    logic   cmp_lt;
    logic   do_reset;

    assign sel_timer = timers[insn_arg[1:0]];
    assign limit     = timer_t'(imm);  // Zero extended
    assign cmp_eq    = sel_timer == limit;
    assign cmp_lt    = sel_timer < limit;

    // Zero outside a compare
    assign cmp_result = cmp_en && (insn_arg[2] ? cmp_eq : cmp_lt);

    assign do_reset = reset_en && stack_top;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `MON_TIMERS; i++) begin
            if (reset) begin
                timers[i] <= '0;
            end else if (do_reset && insn_arg[i]) begin
                timers[i] <= '0;  // Reads 1 after the next flush
            end else if (tick && timers[i] != '1) begin
                timers[i] <= timers[i] + 1'b1;  // Saturates at all ones
            end
        end
    end

endmodule

//--- hw/eval_stack.sv
`include "monitor_settings.svh"

module eval_stack (
    input  logic       clk,
    input  logic       reset,
    input  logic       clear,      // Empty stack at tick start
    input  logic       push_en,
    input  logic       push_val,
    input  logic       logic_en,   // Two pops, then push LUT bit
    input  logic [3:0] lut,
    input  logic       pop_en,
    output logic       stack_top
);
    localparam int depth = `MON_STACK_LEN;

    logic [depth-1:0] stack;   // Bit 0 is the top
    logic             s0;      // Top entry
    logic             s1;      // Entry below top
    logic             lut_bit;

    assign s0        = stack[0];
    assign s1        = stack[1];
    assign lut_bit   = lut[{s1, s0}];
    assign stack_top = stack[0];

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            stack <= '0;
        end else if (push_en) begin
            stack <= {stack[depth-2:0], push_val};  // Deepest bit drops out
        end else if (logic_en) begin
            stack <= {1'b0, stack[depth-1:2], lut_bit};  // Net one pop
        end else if (pop_en) begin
            stack <= {1'b0, stack[depth-1:1]};  // Zero fills bottom
        end
    end

endmodule

//--- hw/io_frame.sv
`include "monitor_settings.svh"

module io_frame (
    input  logic                      clk,
    input  logic                      reset,
    input  monitor_pkg::vec_t         inputs,
    input  logic                      setup,           // Latch inputs
    input  logic                      flush,           // Publish buffer
    input  logic [`MON_ADDR_BITS-1:0] rd_addr,         // Read and edit address
    input  logic                      edit_en,
    input  logic                      edit_val,
    input  logic                      stack_top,       // Edit condition
    input  monitor_pkg::vec_t         cfg_check_mask,
    output logic                      input_bit,
    output monitor_pkg::vec_t         outputs,
    output logic                      violation
);
    import monitor_pkg::*;

    vec_t snapshot;  // Inputs held for the whole tick
    vec_t out_buf;   // Starts as inputs, then edited
    vec_t mismatch;

    assign input_bit = snapshot[rd_addr];
    assign mismatch  = (out_buf ^ snapshot) & cfg_check_mask;

    always_ff @(posedge clk) begin
        if (reset) begin
            snapshot <= '0;
            out_buf  <= '0;
        end else if (setup) begin
            snapshot <= inputs;
            out_buf  <= inputs;
        end else if (edit_en && stack_top) begin
            out_buf[rd_addr] <= edit_val;
        end
    end

    // Visible the cycle after flush
    always_ff @(posedge clk) begin
        if (reset) begin
            outputs   <= '0;
            violation <= 1'b0;
        end else if (flush) begin
            outputs   <= out_buf;
            violation <= |mismatch;  // Any checked bit changed
        end
    end

endmodule

//--- hw/monitor_top.sv
`include "monitor_settings.svh"

module monitor_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              scan_in,
    input  logic              scan_en,
    input  logic              scan_reset,  // Config reset only
    input  monitor_pkg::vec_t inputs,
    output logic              scan_out,
    output monitor_pkg::vec_t outputs,
    output logic              violation,
    output logic              event_setup,
    output logic              event_flush
);
    import monitor_pkg::*;

    pc_t                       cfg_prog_len;
    logic [`MON_TICK_BITS-1:0] cfg_tick_len;
    vec_t                      cfg_check_mask;
    insn_t                     insn;
    logic [7:0]                imm;
    pc_t                       pc;
    logic                      push_en;
    logic                      logic_en;
    logic                      edit_en;
    logic                      timer_cmp_en;
    logic                      timer_reset_en;
    logic                      pop_en;
    logic                      cmp_result;
    logic                      input_bit;
    logic                      stack_top;
    logic                      push_val;

    // Timer compare pushes its result, PUSH pushes a snapshot bit
    assign push_val = timer_cmp_en ? cmp_result : input_bit;

    scan_config i_scan_config (
        .clk            (clk),
        .scan_reset     (scan_reset),
        .scan_en        (scan_en),
        .scan_in        (scan_in),
        .pc             (pc),
        .scan_out       (scan_out),
        .cfg_prog_len   (cfg_prog_len),
        .cfg_tick_len   (cfg_tick_len),
        .cfg_check_mask (cfg_check_mask),
        .insn           (insn),
        .imm            (imm)
    );

    tick_sequencer i_tick_sequencer (
        .clk            (clk),
        .reset          (reset),
        .scan_en        (scan_en),
        .cfg_prog_len   (cfg_prog_len),
        .cfg_tick_len   (cfg_tick_len),
        .insn           (insn),
        .pc             (pc),
        .event_setup    (event_setup),
        .event_flush    (event_flush),
        .push_en        (push_en),
        .logic_en       (logic_en),
        .edit_en        (edit_en),
        .timer_cmp_en   (timer_cmp_en),
        .timer_reset_en (timer_reset_en),
        .pop_en         (pop_en)
    );

    timer_bank i_timer_bank (
        .clk        (clk),
        .reset      (reset),
        .tick       (event_flush),  // Timers count ticks
        .cmp_en     (timer_cmp_en),
        .insn_arg   (insn.arg),
        .imm        (imm),
        .reset_en   (timer_reset_en),
        .stack_top  (stack_top),
        .cmp_result (cmp_result)
    );

    eval_stack i_eval_stack (
        .clk       (clk),
        .reset     (reset),
        .clear     (event_setup),
        .push_en   (push_en),
        .push_val  (push_val),
        .logic_en  (logic_en),
        .lut       (insn.arg[3:0]),
        .pop_en    (pop_en),
        .stack_top (stack_top)
    );

    io_frame i_io_frame (
        .clk            (clk),
        .reset          (reset),
        .inputs         (inputs),
        .setup          (event_setup),
        .flush          (event_flush),
        .rd_addr        (insn.arg),
        .edit_en        (edit_en),
        .edit_val       (insn.flag),  // Value written by EDIT
        .stack_top      (stack_top),
        .cfg_check_mask (cfg_check_mask),
        .input_bit      (input_bit),
        .outputs        (outputs),
        .violation      (violation)
    );

endmodule

//--- verification/monitor_sva.sv
module monitor_sva (
    input logic              clk,
    input logic              reset,
    input logic              scan_en,
    input logic              event_setup,
    input logic              event_flush,
    input logic              violation,
    input monitor_pkg::vec_t outputs
);

    setup_flush_apart: assert property (@(posedge clk) disable iff (reset)
        !(event_setup && event_flush))  // Tick is at least two cycles
        else $error("event_setup and event_flush in the same cycle");

    setup_after_flush: assert property (@(posedge clk) disable iff (reset || scan_en)
        event_flush |=> event_setup)  // Ticks run back to back
        else $error("event_setup did not follow event_flush");

    idle_when_held: assert property (@(posedge clk)
        (reset || scan_en) |=> !(event_setup || event_flush))
        else $error("event pulse while reset or scan_en held the sequencer");

    result_held: assert property (@(posedge clk)
        (!event_flush && !reset) |=> ($stable(outputs) && $stable(violation)))
        else $error("outputs or violation changed outside a flush");

endmodule

bind monitor_top monitor_sva i_monitor_sva (
    .clk         (clk),
    .reset       (reset),
    .scan_en     (scan_en),
    .event_setup (event_setup),
    .event_flush (event_flush),
    .violation   (violation),
    .outputs     (outputs)
);

//--- verification/monitor_tb.sv
`include "monitor_settings.svh"

module monitor_tb;
    import monitor_pkg::*;

    localparam int mem_bits_len = 8 * `MON_MEM_LEN;
    localparam int chain_len    = `MON_PC_BITS + `MON_TICK_BITS + `MON_WIDTH + mem_bits_len;
    localparam int ticks_at     = 3 + `MON_MEM_LEN;  // Word index of the tick count
    localparam int wait_limit   = 1000;               // Cycles per wait

    logic clk = 1'b0;
    logic reset;
    logic scan_in;
    logic scan_en;
    logic scan_reset;
    vec_t inputs;
    logic scan_out;
    vec_t outputs;
    logic violation;
    logic event_setup;
    logic event_flush;

    logic [31:0]             test_data [0:127];  // Words of the data file
    logic [mem_bits_len-1:0] mem_bits;
    logic [chain_len-1:0]    image;              // Chain contents after loading
    logic [chain_len-1:0]    shifted;
    int                      cycle_count = 0;    // Rising edges since start
    int                      tick_len;
    int                      num_ticks;
    int                      base;
    int                      setup_cycle;
    int                      last_flush;

    monitor_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .scan_in     (scan_in),
        .scan_en     (scan_en),
        .scan_reset  (scan_reset),
        .inputs      (inputs),
        .scan_out    (scan_out),
        .outputs     (outputs),
        .violation   (violation),
        .event_setup (event_setup),
        .event_flush (event_flush)
    );

    always #2 clk = ~clk;  // Period 4

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_with_error($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    // Events low, registered outputs still at reset value
    task automatic check_quiet();
        check_value("event_setup", 32'(event_setup), 32'h0);
        check_value("event_flush", 32'(event_flush), 32'h0);
        check_value("outputs", outputs, 32'h0);
        check_value("violation", 32'(violation), 32'h0);
    endtask

    // Sampled at falling edges only
    task automatic wait_for_event(input logic flush_sel);
        int n;
        n = 0;
        while ((flush_sel ? event_flush : event_setup) !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) begin
                if (flush_sel) begin
                    stop_with_error("timeout while waiting for event_flush");
                end else begin
                    stop_with_error("timeout while waiting for event_setup");
                end
            end
        end
    endtask

    task automatic shift_bit(input logic value);
        scan_in = value;
        @(negedge clk);
        check_quiet();  // Sequencer idle while scanning
    endtask

    task automatic load_image();
        logic [chain_len-1:0] bits;
        bits    = image;
        scan_en = 1'b1;
        repeat (chain_len) begin
            shift_bit(bits[chain_len-1]);  // Deepest bit first
            bits = bits << 1;
        end
    endtask

    initial begin
        reset      = 1'b1;
        scan_reset = 1'b1;
        scan_en    = 1'b0;
        scan_in    = 1'b0;
        inputs     = '0;
        $readmemh("verification/monitor_tests.txt", test_data);
        tick_len  = int'(test_data[1][`MON_TICK_BITS-1:0]);
        num_ticks = int'(test_data[ticks_at]);

        mem_bits = '0;
        for (int i = `MON_MEM_LEN - 1; i >= 0; i--) begin
            mem_bits = {mem_bits[mem_bits_len-9:0], test_data[3 + i][7:0]};  // Byte 0 lowest
        end
        image = {mem_bits, test_data[2][`MON_WIDTH-1:0], test_data[1][`MON_TICK_BITS-1:0],
                 test_data[0][`MON_PC_BITS-1:0]};

        repeat (2) begin
            @(negedge clk);
            check_quiet();
        end
        reset      = 1'b0;
        scan_reset = 1'b0;

        load_image();
        shifted = image;
        for (int k = 0; k < chain_len; k++) begin
            check_value("scan_out", 32'(scan_out), 32'(shifted[chain_len-1]));  // Image comes back
            shifted = shifted << 1;
            shift_bit(1'b0);
        end
        load_image();  // Restore what the zeros pushed out
        scan_en    = 1'b0;
        last_flush = -1;

        for (int t = 0; t < num_ticks; t++) begin
            base = ticks_at + 1 + 3 * t;
            wait_for_event(1'b0);
            setup_cycle = cycle_count;
            inputs      = test_data[base];  // Sampled at this setup edge
            @(negedge clk);
            wait_for_event(1'b1);
            check_value("event_setup to event_flush cycles", 32'(cycle_count - setup_cycle),
                        32'(tick_len - 1));
            if (last_flush >= 0) begin
                check_value("event_flush period", 32'(cycle_count - last_flush), 32'(tick_len));
            end
            last_flush = cycle_count;
            @(negedge clk);  // Flush edge passed
            check_value("outputs", outputs, test_data[base + 1]);
            check_value("violation", 32'(violation), test_data[base + 2]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verification/monitor_tests.txt
// Scan image: prog_len, tick_len, check_mask, then program bytes 0-31, eight per line
// Tick count, then one tick per line: inputs, expected outputs, expected violation
0e
0010
80000100
00 01 48 a8 e0 c0 03 90  // push 0, push 1, and, set bit 8, pop, t0 < 3, clear bit 16
e0 02 e2 c5 01 bf 00 00  // pop, push 2, reset t1, t1 == 1, set bit 31
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
0a
00010003 00000103 1  // Bit 8 set by and, bit 16 cleared
80010001 80000001 0  // t1 reads 1, bit 31 already set
00010004 00000004 0  // t1 reset this tick
00010000 80010000 1  // t1 reads 1 after reset
00000103 00000103 0  // Bit 8 already set
12345678 12345678 0  // No edit applies
00000005 00000005 0  // t1 reset again
7ffffefb fffffffb 1  // Bits 8 and 31 set
ffffffff ffffffff 0  // Edits leave all ones
00000000 80000000 1  // t1 reads 1 after reset

//--- flist.f
+incdir+common
common/monitor_pkg.sv
hw/scan_config.sv
hw/tick_sequencer.sv
hw/timer_bank.sv
hw/eval_stack.sv
hw/io_frame.sv
hw/monitor_top.sv
verification/monitor_sva.sv
verification/monitor_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the monitor testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module monitor_tb -f flist.f --Mdir build -o monitor_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./build/monitor_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
